//--- hw/nrvPkg.sv
// Shared types for the core. Enum encodings follow the RV32I funct3 and opcode fields exactly
package nrvPkg;

   // ALU operation as coded in funct3
   typedef enum logic [2:0] {
      ADD  = 3'b000,                      // ADD or SUB with qualifier
      SLL  = 3'b001,
      SLT  = 3'b010,
      SLTU = 3'b011,
      XOR  = 3'b100,
      SR   = 3'b101,                      // SRL or SRA with qualifier
      OR   = 3'b110,
      AND  = 3'b111
   } aluOpE;

   typedef enum logic [2:0] {
      BEQ  = 3'b000,
      BNE  = 3'b001,
      BLT  = 3'b100,
      BGE  = 3'b101,
      BLTU = 3'b110,
      BGEU = 3'b111
   } branchOpE;                           // Codes 010 and 011 are never taken

   // Major opcodes that the core executes
   typedef enum logic [6:0] {
      LUI    = 7'b0110111,
      AUIPC  = 7'b0010111,
      JAL    = 7'b1101111,
      JALR   = 7'b1100111,
      BRANCH = 7'b1100011,
      OPIMM  = 7'b0010011,
      OP     = 7'b0110011,
      LOAD   = 7'b0000011,
      STORE  = 7'b0100011
   } opcodeE;

   typedef enum logic [2:0] {IDLE, EXEC, WAITALU, MEMRD, RETIRE} coreStateE;

   typedef struct packed {
      logic [4:0]  writeBackRegId;
      logic        writeBackEn;
      logic [3:0]  writeBackSel;          // One-hot ALU, PC+4, RAM, counter slot
      logic [4:0]  inRegId1;
      logic [4:0]  inRegId2;
      logic        aluSel;                // 0 forces ADD
      logic        aluInSel1;             // 0 reg  1 pc
      logic        aluInSel2;             // 0 reg  1 imm
      aluOpE       aluOp;
      logic        aluQual;               // SUB or SRA
      logic        isLoad;
      logic        isStore;
      logic        needWaitALU;           // Shifter takes several cycles
      logic [2:0]  nextPCSel;             // One-hot PC+4, ALU, predicated
      logic [31:0] imm;
      logic        error;
   } decodeT;

   typedef struct packed {
      logic [31:0] pc;
      logic [31:0] nextPc;
      logic [4:0]  rd;
      logic        wbEn;
      logic [31:0] wbData;                // Zero when nothing is written
      logic        error;
   } retireT;

endpackage

//--- hw/nrvDecoder.sv
// Pure combinational RV32I decoder with FENCE, SYSTEM and RV32M encodings all flagged as error
`timescale 1ns/100ps

module nrvDecoder (
   input  logic [31:0]    instr,
   output nrvPkg::decodeT dec
);

   logic [31:0] iImm;
   logic [31:0] sImm;
   logic [31:0] bImm;
   logic [31:0] jImm;
   logic [31:0] uImm;
   logic        opIsShift;
   logic        inRegId1Sel;

   // Every format sign extends from bit 31
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   assign uImm = {instr[31:12], 12'h000};

   assign opIsShift = (instr[14:12] == 3'b001) || (instr[14:12] == 3'b101); // SLL or SRL/SRA

   always_comb begin
      dec                = '0;
      inRegId1Sel        = 1'b1;                          // rs1 from instruction by default
      dec.writeBackRegId = instr[11:7];                   // Fixed position fields
      dec.inRegId2       = instr[24:20];
      dec.aluOp          = nrvPkg::aluOpE'(instr[14:12]);
      dec.nextPCSel      = 3'b001;                        // PC+4 unless changed below
      case (nrvPkg::opcodeE'(instr[6:0]))
         nrvPkg::LUI: begin
            dec.writeBackEn  = 1'b1;
            dec.writeBackSel = 4'b0001;                   // x0 plus imm through the adder
            inRegId1Sel      = 1'b0;
            dec.aluInSel2    = 1'b1;
            dec.imm          = uImm;
         end
         nrvPkg::AUIPC: begin
            dec.writeBackEn  = 1'b1;
            dec.writeBackSel = 4'b0001;
            dec.aluInSel1    = 1'b1;                      // pc plus imm
            dec.aluInSel2    = 1'b1;
            dec.imm          = uImm;
         end
         nrvPkg::JAL: begin
            dec.writeBackEn  = 1'b1;
            dec.writeBackSel = 4'b0010;                   // Link value
            dec.aluInSel1    = 1'b1;
            dec.aluInSel2    = 1'b1;
            dec.nextPCSel    = 3'b010;                    // Target from adder
            dec.imm          = jImm;
         end
         nrvPkg::JALR: begin
            dec.writeBackEn  = 1'b1;
            dec.writeBackSel = 4'b0010;
            dec.aluInSel2    = 1'b1;                      // rs1 plus imm
            dec.nextPCSel    = 3'b010;
            dec.imm          = iImm;
         end
         nrvPkg::BRANCH: begin
            dec.nextPCSel = 3'b100;                       // ALU compares rs1 with rs2
            dec.imm       = bImm;                         // Target adder sits in the core
         end
         nrvPkg::OPIMM: begin
            dec.writeBackEn  = 1'b1;
            dec.writeBackSel = 4'b0001;
            dec.aluInSel2    = 1'b1;
            dec.aluSel       = 1'b1;
            dec.aluQual      = opIsShift & instr[30];     // Only SRAI is qualified
            dec.needWaitALU  = opIsShift;
            dec.imm          = iImm;
         end
         nrvPkg::OP: begin
            dec.writeBackEn  = 1'b1;
            dec.writeBackSel = 4'b0001;
            dec.aluSel       = 1'b1;
            dec.aluQual      = instr[30];                 // SUB and SRA
            dec.needWaitALU  = opIsShift;
            dec.error        = instr[25];                 // No RV32M
         end
         nrvPkg::LOAD: begin
            dec.writeBackEn  = 1'b1;
            dec.writeBackSel = 4'b0100;
            dec.aluInSel2    = 1'b1;                      // Address is rs1 plus imm
            dec.isLoad       = 1'b1;
            dec.imm          = iImm;
         end
         nrvPkg::STORE: begin
            dec.aluInSel2 = 1'b1;
            dec.isStore   = 1'b1;
            dec.imm       = sImm;
         end
         default: dec.error = 1'b1;                       // FENCE, SYSTEM and unknown
      endcase
      dec.inRegId1 = instr[19:15] & {5{inRegId1Sel}};
      if (dec.error) begin
         dec.writeBackEn  = 1'b0;                         // Error retires as a plain step
         dec.writeBackSel = 4'b0000;
         dec.needWaitALU  = 1'b0;
         dec.isLoad       = 1'b0;
         dec.nextPCSel    = 3'b001;
      end
   end

endmodule

//--- hw/nrvAlu.sv
// RV32I ALU with a bit-serial shifter and only the shift result held after the op
`timescale 1ns/100ps

module nrvAlu (
   input  logic             clk,
   input  logic             reset,
   input  logic             start,
   input  logic [31:0]      a,
   input  logic [31:0]      b,
   input  nrvPkg::aluOpE    op,
   input  logic             qual,
   input  logic             useOp,
   input  nrvPkg::branchOpE branchOp,
   output logic [31:0]      result,
   output logic             predicate,
   output logic             aluBusy
);

   logic [32:0] diff;
   logic        ltSigned;
   logic        ltUnsigned;
   logic        isShift;
   logic [31:0] shReg;
   logic [4:0]  shCnt;
   logic        shLeft;
   logic        shArith;

   assign diff       = {1'b0, a} - {1'b0, b};
   assign ltUnsigned = diff[32];                              // Borrow out
   assign ltSigned   = (a[31] ^ b[31]) ? a[31] : diff[31];   // Signs differ, negative wins
   assign isShift    = useOp && ((op == nrvPkg::SLL) || (op == nrvPkg::SR));

   always_comb begin
      if (!useOp) begin
         result = a + b;                                      // Address and link targets
      end else begin
         case (op)
            nrvPkg::ADD:  result = qual ? diff[31:0] : a + b;
            nrvPkg::SLT:  result = {31'd0, ltSigned};
            nrvPkg::SLTU: result = {31'd0, ltUnsigned};
            nrvPkg::XOR:  result = a ^ b;
            nrvPkg::OR:   result = a | b;
            nrvPkg::AND:  result = a & b;
            default:      result = shReg;                     // SLL and SR
         endcase
      end
   end

   always_comb begin
      case (branchOp)
         nrvPkg::BEQ:  predicate = (a == b);
         nrvPkg::BNE:  predicate = (a != b);
         nrvPkg::BLT:  predicate = ltSigned;
         nrvPkg::BGE:  predicate = !ltSigned;
         nrvPkg::BLTU: predicate = ltUnsigned;
         nrvPkg::BGEU: predicate = !ltUnsigned;
         default:      predicate = 1'b0;
      endcase
   end

   // One position per cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         aluBusy <= 1'b0;
         shCnt   <= 5'd0;
      end else if (start && isShift) begin
         aluBusy <= (b[4:0] != 5'd0);                         // Zero amount finishes at once
         shCnt   <= b[4:0];
      end else if (aluBusy) begin
         aluBusy <= (shCnt != 5'd1);
         shCnt   <= shCnt - 5'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (start && isShift) begin
         shReg   <= a;
         shLeft  <= (op == nrvPkg::SLL);
         shArith <= qual;
      end else if (aluBusy) begin
         shReg <= shLeft ? {shReg[30:0], 1'b0} : {shArith & shReg[31], shReg[31:1]};
      end
   end

endmodule

//--- hw/nrvRegFile.sv
// Register file with x0 hardwired to zero, combinational reads and no write-through
`timescale 1ns/100ps

module nrvRegFile (
   input  logic        clk,
   input  logic        reset,
   input  logic [4:0]  rs1,
   input  logic [4:0]  rs2,
   output logic [31:0] rd1,
   output logic [31:0] rd2,
   input  logic        we,
   input  logic [4:0]  wa,
   input  logic [31:0] wd
);

   logic [31:0] regs [1:31];                              // No storage for x0

   assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
   assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= 32'd0;
         end
      end else if (we && (wa != 5'd0)) begin                // Writes to x0 dropped
         regs[wa] <= wd;
      end
   end

endmodule

//--- hw/nrvDataRam.sv
// Word RAM with a registered read. Byte offset ignored and the address wraps at RAMWORDS
`timescale 1ns/100ps

module nrvDataRam #(
   parameter int RAMWORDS = 64                              // Power of two
) (
   input  logic        clk,
   input  logic [31:0] addr,
   input  logic        we,
   input  logic [31:0] wd,
   output logic [31:0] rd
);

   localparam int AW = $clog2(RAMWORDS);

   logic [31:0]   mem [0:RAMWORDS-1];
   logic [AW-1:0] idx;

   assign idx = addr[AW+1:2];                               // Word index

   always_ff @(posedge clk) begin
      if (we) begin
         mem[idx] <= wd;
      end
      rd <= mem[idx];                                       // Old data on a write cycle
   end

endmodule

//--- hw/nrvCore.sv
// Multi-cycle RV32I core with one instruction in flight and no instruction memory inside
`timescale 1ns/100ps

module nrvCore #(
   parameter logic [31:0] RESETPC  = 32'h0000_0000,
   parameter int          RAMWORDS = 64
) (
   input  logic           clk,
   input  logic           reset,
   input  logic           instrValid,
   input  logic [31:0]    instr,
   output logic           instrReady,
   output logic           retireValid,
   output nrvPkg::retireT retire,
   input  logic           retireReady
);

   nrvPkg::coreStateE state;
   nrvPkg::decodeT    dec;
   logic [31:0]       instrReg;
   logic [31:0]       pc;
   logic [31:0]       pcPlus4;
   logic [31:0]       pcImm;
   logic [31:0]       nextPc;
   logic [31:0]       rd1;
   logic [31:0]       rd2;
   logic [31:0]       aluA;
   logic [31:0]       aluB;
   logic [31:0]       aluResult;
   logic              predicate;
   logic              aluBusy;
   logic              aluStart;
   logic              ramWe;
   logic [31:0]       ramRd;
   logic [31:0]       wbData;
   logic              wbEn;
   logic              retireFire;

   nrvDecoder decoder (.instr(instrReg), .dec(dec));

   nrvRegFile regFile (
      .clk(clk), .reset(reset),
      .rs1(dec.inRegId1), .rs2(dec.inRegId2), .rd1(rd1), .rd2(rd2),
      .we(retireFire && wbEn), .wa(dec.writeBackRegId), .wd(wbData)
   );

   nrvAlu alu (
      .clk(clk), .reset(reset), .start(aluStart), .a(aluA), .b(aluB),
      .op(dec.aluOp), .qual(dec.aluQual), .useOp(dec.aluSel),
      .branchOp(nrvPkg::branchOpE'(dec.aluOp)),              // Branch funct3 shares aluOp bits
      .result(aluResult), .predicate(predicate), .aluBusy(aluBusy)
   );

   nrvDataRam #(.RAMWORDS(RAMWORDS)) dataRam (
      .clk(clk), .addr(aluResult), .we(ramWe), .wd(rd2), .rd(ramRd)   // Address is ALU sum
   );

   assign instrReady  = (state == nrvPkg::IDLE) && !reset;  // Low while reset is held
   assign retireValid = (state == nrvPkg::RETIRE);
   assign retireFire  = retireValid && retireReady;
   assign aluStart    = (state == nrvPkg::EXEC) && !dec.error;
   assign ramWe       = (state == nrvPkg::EXEC) && dec.isStore && !dec.error;

   assign aluA    = dec.aluInSel1 ? pc : rd1;
   assign aluB    = dec.aluInSel2 ? dec.imm : rd2;
   assign pcPlus4 = pc + 32'd4;
   assign pcImm   = pc + dec.imm;                            // Branch target
   assign wbEn    = dec.writeBackEn && !dec.error;

   // One-hot select, zero when nothing is written
   assign wbData = ({32{dec.writeBackSel[0]}} & aluResult)
                 | ({32{dec.writeBackSel[1]}} & pcPlus4)
                 | ({32{dec.writeBackSel[2]}} & ramRd);

   always_comb begin
      if (dec.error || dec.nextPCSel[0]) begin
         nextPc = pcPlus4;
      end else if (dec.nextPCSel[1]) begin
         nextPc = {aluResult[31:1], 1'b0};                   // JALR clears bit 0
      end else if (dec.nextPCSel[2] && predicate) begin
         nextPc = pcImm;                                     // Taken branch
      end else begin
         nextPc = pcPlus4;
      end
   end

   always_comb begin
      retire.pc     = pc;
      retire.nextPc = nextPc;
      retire.rd     = dec.writeBackRegId;
      retire.wbEn   = wbEn;
      retire.wbData = wbData;
      retire.error  = dec.error;
   end

   always_ff @(posedge clk) begin
      if (instrReady && instrValid) begin
         instrReg <= instr;                                  // Held until the next accept
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= nrvPkg::IDLE;
         pc    <= RESETPC;
      end else begin
         case (state)
            nrvPkg::IDLE: begin
               if (instrValid) state <= nrvPkg::EXEC;
            end
            nrvPkg::EXEC: begin
               if (dec.error) state <= nrvPkg::RETIRE;
               else if (dec.isLoad) state <= nrvPkg::MEMRD;        // Registered RAM read
               else if (dec.needWaitALU) state <= nrvPkg::WAITALU;
               else state <= nrvPkg::RETIRE;
            end
            nrvPkg::WAITALU: begin
               if (!aluBusy) state <= nrvPkg::RETIRE;              // Shifter done
            end
            nrvPkg::MEMRD: state <= nrvPkg::RETIRE;
            nrvPkg::RETIRE: begin
               if (retireReady) begin
                  pc    <= nextPc;                                  // Same edge as reg write
                  state <= nrvPkg::IDLE;
               end
            end
            default: state <= nrvPkg::IDLE;
         endcase
      end
   end

endmodule

//--- sim/nrvCoreAssertions.sv
// Handshake and reset checks bound into nrvCore that assume reset is held for whole clock cycles
`timescale 1ns/100ps

module nrvCoreAssertions (
   input logic           clk,
   input logic           reset,
   input logic           instrValid,
   input logic           instrReady,
   input logic           retireValid,
   input nrvPkg::retireT retire,
   input logic           retireReady
);

   // A busy or just accepting core stays unready until the retire handshake
   readyOnlyInIdle: assert property (@(posedge clk)
      (!reset && !(retireValid && retireReady) && (instrValid || !instrReady))
      |=> !instrReady)
      else $error("instrReady high while an instruction is in flight");

   recordHeld: assert property (@(posedge clk) disable iff (reset)
      (retireValid && !retireReady) |=> (retireValid && $stable(retire)))
      else $error("retirement record changed under back-pressure");

   // Ready rises only once reset has gone
   quietAfterReset: assert property (@(posedge clk)
      reset |=> !retireValid && (instrReady == !reset))
      else $error("instrReady or retireValid wrong in the cycle after reset");

endmodule

bind nrvCore nrvCoreAssertions handshakeChecks (
   .clk(clk), .reset(reset), .instrValid(instrValid), .instrReady(instrReady),
   .retireValid(retireValid), .retire(retire), .retireReady(retireReady)
);

//--- sim/nrvCoreTb.sv
// Random RV32I stream checked against a model. Loads only read RAM words that were stored before
`timescale 1ns/100ps

module nrvCoreTb;

   localparam logic [31:0] RESETPC   = 32'h0000_1000;
   localparam int          RAMWORDS  = 64;
   localparam int          NUMINSTR  = 600;
   localparam int          MAXCYCLES = NUMINSTR * 40 + 20;   // Worst shift plus handshake waits

   logic           clk;
   logic           reset;
   logic           instrValid;
   logic [31:0]    instr;
   logic           instrReady;
   logic           retireValid;
   nrvPkg::retireT retire;
   logic           retireReady;

   integer         seed;
   int             cycles = 0;
   logic [31:0]    pcModel;
   logic [31:0]    regModel [0:31];
   logic [31:0]    ramModel [0:RAMWORDS-1];
   bit             ramWritten [0:RAMWORDS-1];

   nrvCore #(.RESETPC(RESETPC), .RAMWORDS(RAMWORDS)) uut (
      .clk(clk), .reset(reset), .instrValid(instrValid), .instr(instr),
      .instrReady(instrReady), .retireValid(retireValid), .retire(retire),
      .retireReady(retireReady)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAXCYCLES) begin
         $display("Timeout after %0d cycles with instructions still outstanding", cycles);
         $display("Test failed");
         $fatal(1);
      end
   end

   function automatic logic [31:0] randBelow(input int unsigned n);
      return {$random(seed)} % n;
   endfunction

   // RV32I integer operation from funct3 and the bit 30 qualifier
   function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
      logic signed [31:0] sa;
      sa = a;
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return {31'd0, $signed(a) < $signed(b)};
         3'd3:    return {31'd0, a < b};
         3'd4:    return a ^ b;
         3'd5: begin
            if (alt) return sa >>> b[4:0];                   // SRA keeps the sign
            return a >> b[4:0];
         end
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   // Draws one instruction and advances the model past it
   task automatic makeInstr(output logic [31:0] w, output nrvPkg::retireT exp);
      int unsigned cls, idx;
      logic [4:0]  rd, rs1, rs2;
      logic [2:0]  f3;
      logic [6:0]  op;
      logic [11:0] imm12;
      logic [31:0] r, a, b, imm;
      logic        alt;
      cls   = randBelow(10);
      idx   = randBelow(RAMWORDS);
      rd    = randBelow(32);
      rs1   = randBelow(32);
      rs2   = randBelow(32);
      f3    = randBelow(8);
      imm12 = randBelow(4096);
      r     = {$random(seed)};
      a     = regModel[rs1];
      b     = regModel[rs2];
      if (cls == 8 && !ramWritten[idx]) cls = 7;             // Store first, load later
      exp        = '0;
      exp.pc     = pcModel;
      exp.nextPc = pcModel + 32'd4;
      case (cls)
         0: begin                                            // R-type
            alt        = (f3 == 3'd0 || f3 == 3'd5) && randBelow(2);
            w          = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
            exp.wbEn   = 1'b1;
            exp.wbData = aluModel(f3, alt, a, b);
         end
         1: begin                                            // Immediate form
            if (f3 == 3'd1) imm12 = {7'd0, imm12[4:0]};
            if (f3 == 3'd5) imm12 = {1'b0, imm12[10], 5'd0, imm12[4:0]};
            w          = {imm12, rs1, f3, rd, 7'b0010011};
            exp.wbEn   = 1'b1;
            exp.wbData = aluModel(f3, (f3 == 3'd5) && imm12[10], a, {{20{imm12[11]}}, imm12});
         end
         2, 3: begin                                         // LUI and AUIPC
            imm        = r & 32'hffff_f000;
            w          = {imm[31:12], rd, (cls == 2) ? 7'b0110111 : 7'b0010111};
            exp.wbEn   = 1'b1;
            exp.wbData = (cls == 2) ? imm : pcModel + imm;
         end
         4: begin
            imm        = {{11{r[20]}}, r[20:1], 1'b0};
            w          = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            exp.wbEn   = 1'b1;
            exp.wbData = pcModel + 32'd4;                    // Link value
            exp.nextPc = pcModel + imm;
         end
         5: begin
            w          = {imm12, rs1, 3'b000, rd, 7'b1100111};
            exp.wbEn   = 1'b1;
            exp.wbData = pcModel + 32'd4;
            exp.nextPc = (a + {{20{imm12[11]}}, imm12}) & ~32'd1;   // Bit 0 cleared
         end
         6: begin
            if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 ^ 3'b100;  // Only the six real conditions
            imm = {{19{r[12]}}, r[12:1], 1'b0};
            w   = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
            if (branchTaken(f3, a, b)) exp.nextPc = pcModel + imm;
         end
         7: begin                                            // SW with base x0
            imm              = idx << 2;
            w                = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
            ramModel[idx]    = b;
            ramWritten[idx]  = 1'b1;
         end
         8: begin                                            // LW with base x0
            imm        = idx << 2;
            w          = {imm[11:0], 5'd0, 3'b010, rd, 7'b0000011};
            exp.wbEn   = 1'b1;
            exp.wbData = ramModel[idx];
         end
         default: begin                                      // Unsupported encodings
            op = randBelow(128);
            while (op inside {7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h13, 7'h33, 7'h03, 7'h23})
               op = randBelow(128);
            case (randBelow(4))
               0:       w = {r[31:26], 1'b1, rs2, rs1, f3, rd, 7'b0110011};   // RV32M
               1:       w = {r[31:7], 7'b0001111};                         // FENCE
               2:       w = {r[31:7], 7'b1110011};                         // SYSTEM
               default: w = {r[31:7], op};
            endcase
            exp.error = 1'b1;
         end
      endcase
      exp.rd = w[11:7];                                      // Field as encoded
      if (exp.wbEn && exp.rd != 5'd0) regModel[exp.rd] = exp.wbData;
      pcModel = exp.nextPc;
   endtask

   task automatic compareField(input string name, input logic [31:0] expV,
                               input logic [31:0] gotV);
      assert (gotV === expV) else begin
         $display("mismatch %s exp %h got %h", name, expV, gotV);
         $display("Test failed");
         $fatal(1);
      end
   endtask

   initial begin
      nrvPkg::retireT exp;
      logic [31:0]    w;
      seed        = 60527;
      reset       = 1'b1;
      instrValid  = 1'b0;
      instr       = 32'd0;
      retireReady = 1'b0;
      pcModel     = RESETPC;
      for (int i = 0; i < 32; i++) begin
         regModel[i] = 32'd0;                                // Registers clear on reset
      end
      for (int i = 0; i < RAMWORDS; i++) begin
         ramWritten[i] = 1'b0;
      end
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      for (int n = 0; n < NUMINSTR; n++) begin
         makeInstr(w, exp);
         repeat (randBelow(3)) @(posedge clk);               // Random gap before valid
         instrValid <= 1'b1;
         instr      <= w;
         do @(posedge clk); while (!instrReady);             // Accept edge
         instrValid <= 1'b0;
         do begin
            @(posedge clk);
            if (!(retireValid && retireReady)) retireReady <= randBelow(2);
         end while (!(retireValid && retireReady));
         compareField("pc", exp.pc, retire.pc);
         compareField("nextPc", exp.nextPc, retire.nextPc);
         compareField("rd", {27'd0, exp.rd}, {27'd0, retire.rd});
         compareField("wbEn", {31'd0, exp.wbEn}, {31'd0, retire.wbEn});
         compareField("wbData", exp.wbData, retire.wbData);
         compareField("error", {31'd0, exp.error}, {31'd0, retire.error});
         retireReady <= randBelow(2);
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- nrvCore.f
hw/nrvPkg.sv
hw/nrvDecoder.sv
hw/nrvAlu.sv
hw/nrvRegFile.sv
hw/nrvDataRam.sv
hw/nrvCore.sv
sim/nrvCoreAssertions.sv
sim/nrvCoreTb.sv
